/* src/irq_pkg.sv */
package irq_pkg;

	// Sizes
	localparam int irq_count = 8;			// Interrupt sources
	localparam int irq_idx_w = 3;			// Source index width

	// Register map on the CPU data bus
	localparam logic [15:0] ie_addr = 16'hffff;		// Interrupt enable
	localparam logic [15:0] if_addr = 16'hff0f;		// Interrupt flags

	// Vector of source 0 with later vectors 8 bytes apart
	localparam logic [7:0] vector_base = 8'h40;

	// Returned for reads outside IE and IF
	localparam logic [7:0] unmapped_read = 8'hff;

	// CPU bus request for one transfer
	typedef struct packed {
		logic [15:0] addr;		// Byte address
		logic [7:0]  wdata;		// Write data
		logic        wr;		// Write strobe
		logic        rd;		// Read strobe
	} irq_bus_req_t;

	// Register access selects
	typedef struct packed {
		logic ie_wr;
		logic if_wr;
		logic ie_rd;
		logic if_rd;
	} irq_sel_t;

	// Arbiter result
	typedef struct packed {
		logic                 valid;		// Dispatch granted this cycle
		logic [irq_idx_w-1:0] index;		// Winning source
	} irq_grant_t;

endpackage

/* src/irq_reg_decode.sv */
module irq_reg_decode
	import irq_pkg::*;
(
	input  irq_bus_req_t bus_req,
	output irq_sel_t     sel
);

	logic ie_hit;		// Address matches IE
	logic if_hit;		// Address matches IF

	// Full 16-bit compare against each register address
	assign ie_hit = (bus_req.addr == ie_addr);
	assign if_hit = (bus_req.addr == if_addr);

	// Qualify hits with the strobes
	always_comb begin
		sel = '0;
		if (bus_req.wr) begin
			sel.ie_wr = ie_hit;
			sel.if_wr = if_hit;
		end
		if (bus_req.rd) begin
			sel.ie_rd = ie_hit;
			sel.if_rd = if_hit;
		end
	end

endmodule

/* src/irq_flag_bank.sv */
module irq_flag_bank
	import irq_pkg::*;
(
	input  logic                 clk,
	input  logic                 arst_n,
	input  irq_sel_t             sel,
	input  logic [7:0]           wdata,
	input  logic [irq_count-1:0] irq_trig,
	input  irq_grant_t           grant,
	output logic [irq_count-1:0] ie_q,
	output logic [irq_count-1:0] if_q,
	output logic [irq_count-1:0] pending
);

	logic [irq_count-1:0] trig_q;		// Trigger levels at previous edge
	logic [irq_count-1:0] trig_rise;	// Low to high since last edge
	logic [irq_count-1:0] clr_mask;	// One-hot of the granted source
	logic [irq_count-1:0] if_d;		// Next flag value

	assign trig_rise = irq_trig & ~trig_q;

	// Only the granted flag is cleared
	always_comb begin
		clr_mask = '0;
		if (grant.valid)
			clr_mask[grant.index] = 1'b1;
	end

	// Write first, then clear, then set
	always_comb begin
		if_d = sel.if_wr ? wdata : if_q;
		if_d = if_d & ~clr_mask;
		if_d = if_d | trig_rise;		// New trigger beats clear and write
	end

	// Trigger history
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			trig_q <= '0;
		else
			trig_q <= irq_trig;
	end

	// Enable register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			ie_q <= '0;
		else if (sel.ie_wr)
			ie_q <= wdata;
	end

	// Flag register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			if_q <= '0;
		else
			if_q <= if_d;
	end

	// Sources that are both flagged and enabled
	assign pending = ie_q & if_q;

endmodule

/* src/irq_priority_arbiter.sv */
module irq_priority_arbiter
	import irq_pkg::*;
(
	input  logic [irq_count-1:0] pending,
	input  logic                 ime,
	input  logic                 dispatch_req,
	output irq_grant_t           grant,
	output logic                 irq_pending
);

	logic                 any_pending;		// At least one source ready
	logic [irq_idx_w-1:0] low_idx;		// Lowest set bit

	assign any_pending = |pending;

	// Scan from the top so the lowest index ends up winning
	always_comb begin
		low_idx = '0;
		for (int i = irq_count - 1; i >= 0; i--) begin
			if (pending[i])
				low_idx = irq_idx_w'(i);
		end
	end

	// Dispatch only at an instruction boundary with IME set
	always_comb begin
		grant.valid = dispatch_req & ime & any_pending;
		grant.index = low_idx;
	end

	// Wake for halt does not care about IME
	assign irq_pending = any_pending;

endmodule

/* src/irq_result_stage.sv */
module irq_result_stage
	import irq_pkg::*;
(
	input  logic                 clk,
	input  logic                 arst_n,
	input  irq_sel_t             sel,
	input  logic                 rd,
	input  logic [irq_count-1:0] ie_q,
	input  logic [irq_count-1:0] if_q,
	input  irq_grant_t           grant,
	output logic [7:0]           rdata,
	output logic [irq_count-1:0] irq_ack,
	output logic [7:0]           irq_vector
);

	logic [7:0]           rdata_d;		// Read mux
	logic [irq_count-1:0] ack_d;		// One-hot of the grant
	logic [7:0]           vector_d;		// Vector for the grant

	// Read from neither register falls through to unmapped
	always_comb begin
		if (sel.ie_rd)
			rdata_d = ie_q;
		else if (sel.if_rd)
			rdata_d = if_q;
		else
			rdata_d = unmapped_read;
	end

	always_comb begin
		ack_d = '0;
		if (grant.valid)
			ack_d[grant.index] = 1'b1;
	end

	// Base plus index times eight
	assign vector_d = vector_base + {2'b00, grant.index, 3'b000};

	// Read data holds until the next read
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			rdata <= '0;
		else if (rd)
			rdata <= rdata_d;
	end

	// Acknowledge is a single-cycle pulse
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			irq_ack <= '0;
		else
			irq_ack <= ack_d;
	end

	// Vector keeps its value between dispatches
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			irq_vector <= '0;
		else if (grant.valid)
			irq_vector <= vector_d;
	end

endmodule

/* src/irq_ctrl_top.sv */
module irq_ctrl_top
	import irq_pkg::*;
(
	input  logic                 clk,
	input  logic                 arst_n,
	input  irq_bus_req_t         bus_req,
	input  logic [irq_count-1:0] irq_trig,
	input  logic                 ime,
	input  logic                 dispatch_req,
	output logic [7:0]           rdata,
	output logic                 irq_pending,
	output logic [irq_count-1:0] irq_ack,
	output logic [7:0]           irq_vector
);

	irq_sel_t             sel;		// Register selects
	logic [irq_count-1:0] ie_q;
	logic [irq_count-1:0] if_q;
	logic [irq_count-1:0] pending;		// IE and IF
	irq_grant_t           grant;

	irq_reg_decode u_decode (
		.bus_req (bus_req),
		.sel     (sel)
	);

	irq_flag_bank u_flag_bank (
		.clk      (clk),
		.arst_n   (arst_n),
		.sel      (sel),
		.wdata    (bus_req.wdata),
		.irq_trig (irq_trig),
		.grant    (grant),
		.ie_q     (ie_q),
		.if_q     (if_q),
		.pending  (pending)
	);

	irq_priority_arbiter u_arbiter (
		.pending      (pending),
		.ime          (ime),
		.dispatch_req (dispatch_req),
		.grant        (grant),
		.irq_pending  (irq_pending)
	);

	irq_result_stage u_result (
		.clk        (clk),
		.arst_n     (arst_n),
		.sel        (sel),
		.rd         (bus_req.rd),
		.ie_q       (ie_q),
		.if_q       (if_q),
		.grant      (grant),
		.rdata      (rdata),
		.irq_ack    (irq_ack),
		.irq_vector (irq_vector)
	);

endmodule

/* verif/irq_ctrl_tb.sv */
module irq_ctrl_tb
	import irq_pkg::*;
();

	localparam int dispatch_timeout = 8;		// Cycles to wait for irq_ack
	localparam int watchdog_cycles = 20000;

	logic                 clk;
	logic                 arst_n;
	irq_bus_req_t         bus_req;
	logic [irq_count-1:0] irq_trig;
	logic                 ime;
	logic                 dispatch_req;
	logic [7:0]           rdata;
	logic                 irq_pending;
	logic [irq_count-1:0] irq_ack;
	logic [7:0]           irq_vector;

	logic [31:0] lcg_state;
	int          err_count;
	int          tests_passed;
	int          tests_failed;

	irq_ctrl_top uut (
		.clk          (clk),
		.arst_n       (arst_n),
		.bus_req      (bus_req),
		.irq_trig     (irq_trig),
		.ime          (ime),
		.dispatch_req (dispatch_req),
		.rdata        (rdata),
		.irq_pending  (irq_pending),
		.irq_ack      (irq_ack),
		.irq_vector   (irq_vector)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;		// Period 20

	function automatic logic [7:0] rand_byte();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];		// Upper bits are less periodic
	endfunction

	// Index of the lowest set bit scanning upward from source 0
	function automatic int lowest_bit(input logic [7:0] v);
		for (int i = 0; i < irq_count; i++) begin
			if (v[i])
				return i;
		end
		return -1;
	endfunction

	task automatic expect_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("ERROR at time %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
			err_count++;
		end
	endtask

	// All bus tasks start and end on a falling edge
	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		bus_req.addr = addr;
		bus_req.wdata = data;
		bus_req.wr = 1'b1;
		@(negedge clk);
		bus_req.wr = 1'b0;
	endtask

	task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
		bus_req.addr = addr;
		bus_req.rd = 1'b1;
		@(negedge clk);
		bus_req.rd = 1'b0;
		data = rdata;		// Registered at the edge just passed
	endtask

	task automatic pulse_trig(input int idx);
		irq_trig[idx] = 1'b1;
		@(negedge clk);
		irq_trig[idx] = 1'b0;
		@(negedge clk);
	endtask

	task automatic dispatch(output logic found, output logic [7:0] ack, output logic [7:0] vec,
			output int waited);
		found = 1'b0;
		ack = '0;
		vec = '0;
		waited = 0;
		dispatch_req = 1'b1;
		@(negedge clk);
		dispatch_req = 1'b0;
		while (!found && waited < dispatch_timeout) begin
			if (irq_ack != '0) begin
				found = 1'b1;
				ack = irq_ack;
				vec = irq_vector;
			end else begin
				@(negedge clk);
				waited++;
			end
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (err_count == errs_before) begin
			$display("Test %s passed", name);
			tests_passed++;
		end else begin
			$display("Test %s failed with %0d errors", name, err_count - errs_before);
			tests_failed++;
		end
	endtask

	task automatic test_reset_state();
		int         errs;
		logic [7:0] data;
		errs = err_count;
		expect_byte("rdata after reset", rdata, 8'h00);
		expect_byte("irq_vector after reset", irq_vector, 8'h00);
		expect_byte("irq_ack after reset", irq_ack, 8'h00);
		expect_byte("irq_pending after reset", {7'd0, irq_pending}, 8'h00);
		bus_read(ie_addr, data);
		expect_byte("IE after reset", data, 8'h00);
		bus_read(if_addr, data);
		expect_byte("IF after reset", data, 8'h00);
		bus_read(16'h1234, data);
		expect_byte("unmapped read", data, 8'hff);
		report_test("reset_state", errs);
	endtask

	task automatic test_register_access();
		int         errs;
		logic [7:0] ie_v;
		logic [7:0] if_v;
		logic [7:0] data;
		errs = err_count;
		for (int n = 0; n < 8; n++) begin
			ie_v = rand_byte();
			if_v = rand_byte();
			bus_write(ie_addr, ie_v);
			bus_write(if_addr, if_v);
			bus_read(ie_addr, data);
			expect_byte("IE readback", data, ie_v);
			bus_read(if_addr, data);
			expect_byte("IF readback", data, if_v);
			@(negedge clk);		// No read strobe this cycle
			expect_byte("rdata held after read", rdata, if_v);
		end
		report_test("register_access", errs);
	endtask

	task automatic test_edge_setting();
		int         errs;
		int         k;
		logic [7:0] data;
		errs = err_count;
		k = rand_byte() % irq_count;
		bus_write(ie_addr, 8'h00);
		bus_write(if_addr, 8'h00);
		irq_trig[k] = 1'b1;		// Rise seen at the next edge
		@(negedge clk);
		bus_read(if_addr, data);
		expect_byte("IF after first rise", data, 8'h01 << k);
		bus_write(if_addr, 8'h00);
		repeat (3) @(negedge clk);		// Trigger still held high
		bus_read(if_addr, data);
		expect_byte("IF with trigger held", data, 8'h00);
		irq_trig[k] = 1'b0;
		@(negedge clk);
		pulse_trig(k);
		bus_read(if_addr, data);
		expect_byte("IF after second rise", data, 8'h01 << k);
		bus_write(if_addr, 8'h00);
		report_test("edge_setting", errs);
	endtask

	task automatic test_priority_dispatch();
		int         errs;
		int         idx;
		int         waited;
		logic [7:0] ie_v;
		logic [7:0] if_v;
		logic [7:0] data;
		logic [7:0] ack;
		logic [7:0] vec;
		logic       found;
		errs = err_count;
		ime = 1'b1;
		for (int n = 0; n < 20; n++) begin
			ie_v = rand_byte();
			if_v = rand_byte();
			if ((ie_v & if_v) == 8'h00) begin
				idx = rand_byte() % irq_count;
				ie_v[idx] = 1'b1;
				if_v[idx] = 1'b1;
			end
			idx = lowest_bit(ie_v & if_v);
			bus_write(ie_addr, ie_v);
			bus_write(if_addr, if_v);
			dispatch(found, ack, vec, waited);
			if (!found) begin
				$display("Timeout: no acknowledge within %0d cycles of a dispatch request",
					dispatch_timeout);
				err_count++;
			end else begin
				if (waited != 0) begin
					$display("ERROR at time %0t: irq_ack came %0d cycles late", $time, waited);
					err_count++;
				end
				expect_byte("irq_ack", ack, 8'h01 << idx);
				expect_byte("irq_vector", vec, vector_base + 8'(idx * 8));
				@(negedge clk);
				expect_byte("irq_ack one cycle later", irq_ack, 8'h00);
				expect_byte("irq_vector held", irq_vector, vector_base + 8'(idx * 8));
			end
			bus_read(if_addr, data);
			expect_byte("IF after dispatch", data, if_v & ~(8'h01 << idx));
		end
		report_test("priority_dispatch", errs);
	endtask

	task automatic test_masking_wake();
		int         errs;
		int         waited;
		logic [7:0] data;
		logic [7:0] ack;
		logic [7:0] vec;
		logic       found;
		errs = err_count;
		ime = 1'b0;
		bus_write(ie_addr, 8'hff);
		bus_write(if_addr, 8'h01);
		expect_byte("irq_pending with IME low", {7'd0, irq_pending}, 8'h01);
		dispatch(found, ack, vec, waited);
		if (found) begin
			$display("ERROR at time %0t: irq_ack 0x%02h with IME low", $time, ack);
			err_count++;
		end
		expect_byte("irq_pending after masked dispatch", {7'd0, irq_pending}, 8'h01);
		bus_read(if_addr, data);
		expect_byte("IF after masked dispatch", data, 8'h01);
		bus_write(ie_addr, 8'h00);
		bus_write(if_addr, 8'hff);
		expect_byte("irq_pending with IE zero", {7'd0, irq_pending}, 8'h00);
		report_test("masking_wake", errs);
	endtask

	initial begin
		lcg_state = 32'd56;
		err_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		arst_n = 1'b0;
		bus_req = '0;
		irq_trig = '0;
		ime = 1'b0;
		dispatch_req = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		test_reset_state();
		test_register_access();
		test_edge_setting();
		test_priority_dispatch();
		test_masking_wake();
		$display("Tests passed: %0d, failed: %0d, errors: %0d",
			tests_passed, tests_failed, err_count);
		if (tests_failed == 0 && err_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// Guards against a stuck run
	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("The run did not complete within %0d clock cycles", watchdog_cycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* irq_ctrl_top.f */
src/irq_pkg.sv
src/irq_reg_decode.sv
src/irq_flag_bank.sv
src/irq_priority_arbiter.sv
src/irq_result_stage.sv
src/irq_ctrl_top.sv
verif/irq_ctrl_tb.sv
